// File: Makefile
SOURCES := src.f $(wildcard hw/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)

.PHONY: all run lint clean

all: run

obj_dir/Vvideo_gen_tb: $(SOURCES)
	verilator --binary --timing -Wno-fatal -j 0 --top-module video_gen_tb -f src.f

run: obj_dir/Vvideo_gen_tb
	./obj_dir/Vvideo_gen_tb | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module video_gen -f src.f

clean:
	rm -rf obj_dir sim.log

// File: hw/raster_if.sv
// raster position and events; de_next and last_visible_pixel are combinational, the counts registered
`default_nettype none
`timescale 1ns/100ps

interface raster_if import video_pkg::*; ();

    logic [CNT_W-1:0]   h_count;            // current pixel in line
    logic [CNT_W-1:0]   v_count;            // current line in frame
    logic               h_blank;            // h state is not VISIBLE
    logic               v_blank;            // v state is not VISIBLE
    logic               de_next;            // display enable for next cycle
    logic               last_visible_pixel; // last pixel of last visible line

    modport source (
        output h_count, v_count, h_blank, v_blank, de_next, last_visible_pixel
    );

    modport sink (
        input  h_count, v_count, h_blank, v_blank, de_next, last_visible_pixel
    );

endinterface

`default_nettype wire

// File: hw/raster_timing.sv
// sync FSMs for one clock per pixel; every timing value must be at least 1 and totals below 2**CNT_W
`default_nettype none
`timescale 1ns/100ps

module raster_timing import video_pkg::*; #(
    parameter int H_VISIBLE = H_VISIBLE_DEF,
    parameter int H_FRONT   = H_FRONT_DEF,
    parameter int H_SYNC    = H_SYNC_DEF,
    parameter int H_BACK    = H_BACK_DEF,
    parameter int V_VISIBLE = V_VISIBLE_DEF,
    parameter int V_FRONT   = V_FRONT_DEF,
    parameter int V_SYNC    = V_SYNC_DEF,
    parameter int V_BACK    = V_BACK_DEF,
    parameter bit H_POL     = H_POL_DEF,
    parameter bit V_POL     = V_POL_DEF
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    raster_if.source    rif,
    output logic        hsync_o,            // sync outputs at parameter polarity
    output logic        vsync_o,
    output logic        de_o                // display enable
);

    localparam int H_TOTAL = H_FRONT + H_SYNC + H_BACK + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    // last count of each state, blanking sits at the start of a line
    localparam logic [CNT_W-1:0] H_END_FRONT = CNT_W'(H_FRONT - 1);
    localparam logic [CNT_W-1:0] H_END_SYNC  = CNT_W'(H_FRONT + H_SYNC - 1);
    localparam logic [CNT_W-1:0] H_END_BACK  = CNT_W'(H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [CNT_W-1:0] H_END_VIS   = CNT_W'(H_TOTAL - 1);

    // and at the end of a frame vertically
    localparam logic [CNT_W-1:0] V_END_VIS   = CNT_W'(V_VISIBLE - 1);
    localparam logic [CNT_W-1:0] V_END_FRONT = CNT_W'(V_VISIBLE + V_FRONT - 1);
    localparam logic [CNT_W-1:0] V_END_SYNC  = CNT_W'(V_VISIBLE + V_FRONT + V_SYNC - 1);
    localparam logic [CNT_W-1:0] V_END_BACK  = CNT_W'(V_TOTAL - 1);

    sync_state_e        h_state;
    sync_state_e        v_state;
    sync_state_e        h_state_next;
    sync_state_e        v_state_next;
    logic [CNT_W-1:0]   h_end;              // count that ends current h state
    logic [CNT_W-1:0]   v_end;
    logic [CNT_W-1:0]   h_count_next;
    logic [CNT_W-1:0]   v_count_next;
    logic               h_line_last_pixel;
    logic               last_frame_pixel;

    always_comb begin
        case (h_state)
            PRE_SYNC:  h_end = H_END_FRONT;
            SYNC:      h_end = H_END_SYNC;
            POST_SYNC: h_end = H_END_BACK;
            VISIBLE:   h_end = H_END_VIS;
            default:   h_end = H_END_VIS;
        endcase
    end

    always_comb begin
        case (v_state)
            VISIBLE:   v_end = V_END_VIS;
            PRE_SYNC:  v_end = V_END_FRONT;
            SYNC:      v_end = V_END_SYNC;
            POST_SYNC: v_end = V_END_BACK;
            default:   v_end = V_END_BACK;
        endcase
    end

    // vertical state only moves on the last pixel of a line
    assign h_state_next = (rif.h_count == h_end) ? sync_state_e'(h_state + 2'd1) : h_state;
    assign v_state_next = (h_line_last_pixel && rif.v_count == v_end) ?
                          sync_state_e'(v_state + 2'd1) : v_state;

    assign h_line_last_pixel = (h_state == VISIBLE) && (h_state_next == PRE_SYNC);
    assign last_frame_pixel  = h_line_last_pixel && (v_state == POST_SYNC) &&
                               (v_state_next == VISIBLE);

    assign rif.last_visible_pixel = h_line_last_pixel && (v_state == VISIBLE) &&
                                    (v_state_next == PRE_SYNC);
    assign rif.de_next = (h_state_next == VISIBLE) && (v_state_next == VISIBLE);
    assign rif.h_blank = (h_state != VISIBLE);
    assign rif.v_blank = (v_state != VISIBLE);

    always_comb begin
        h_count_next = rif.h_count + 1'b1;
        v_count_next = rif.v_count;
        if (h_line_last_pixel) begin
            h_count_next = '0;
            v_count_next = last_frame_pixel ? '0 : rif.v_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state     <= PRE_SYNC;
            v_state     <= VISIBLE;         // first frame starts on a visible line
            rif.h_count <= '0;
            rif.v_count <= '0;
            hsync_o     <= ~H_POL;
            vsync_o     <= ~V_POL;
            de_o        <= 1'b0;
        end else begin
            h_state     <= h_state_next;
            v_state     <= v_state_next;
            rif.h_count <= h_count_next;
            rif.v_count <= v_count_next;
            hsync_o     <= (h_state_next == SYNC) ? H_POL : ~H_POL;
            vsync_o     <= (v_state_next == SYNC) ? V_POL : ~V_POL;
            de_o        <= rif.de_next;     // lines up with registered counts
        end
    end

endmodule

`default_nettype wire

// File: hw/video_gen.sv
// video timing top; one clock per pixel, raster set by parameters, no playfield or memory ports
`default_nettype none
`timescale 1ns/100ps

module video_gen import video_pkg::*; #(
    parameter int H_VISIBLE = H_VISIBLE_DEF,
    parameter int H_FRONT   = H_FRONT_DEF,
    parameter int H_SYNC    = H_SYNC_DEF,
    parameter int H_BACK    = H_BACK_DEF,
    parameter int V_VISIBLE = V_VISIBLE_DEF,
    parameter int V_FRONT   = V_FRONT_DEF,
    parameter int V_SYNC    = V_SYNC_DEF,
    parameter int V_BACK    = V_BACK_DEF,
    parameter bit H_POL     = H_POL_DEF,
    parameter bit V_POL     = V_POL_DEF,
    parameter int VFREQ     = VFREQ_DEF
) (
    input  wire logic               clk,            // pixel clock
    input  wire logic               reset_i,
    input  wire logic               reg_wr_i,
    input  wire xr_num_e            reg_num_i,
    input  wire logic [15:0]        reg_data_i,
    output logic [15:0]             reg_data_o,
    input  wire logic [3:0]         intr_status_i,
    output logic [3:0]              intr_o,
    output logic                    copp_wr_o,
    output logic [15:0]             copp_data_o,
    output logic [CNT_W-1:0]        h_count_o,
    output logic [CNT_W-1:0]        v_count_o,
    output logic [7:0]              color_index_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    de_o
);

    raster_if rif ();

    assign h_count_o = rif.h_count;     // counters also feed the copper
    assign v_count_o = rif.v_count;

    raster_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_POL(H_POL), .V_POL(V_POL)
    ) u_timing (
        .clk(clk),
        .reset_i(reset_i),
        .rif(rif.source),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o),
        .de_o(de_o)
    );

    video_regs #(
        .H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE), .VFREQ(VFREQ)
    ) u_regs (
        .clk(clk),
        .reset_i(reset_i),
        .rif(rif.sink),
        .reg_wr_i(reg_wr_i),
        .reg_num_i(reg_num_i),
        .reg_data_i(reg_data_i),
        .reg_data_o(reg_data_o),
        .intr_status_i(intr_status_i),
        .intr_o(intr_o),
        .copp_wr_o(copp_wr_o),
        .copp_data_o(copp_data_o),
        .color_index_o(color_index_o)
    );

endmodule

`default_nettype wire

// File: hw/video_pkg.sv
// shared video definitions; timing defaults are 640x480 at 60 Hz, totals must fit in CNT_W bits
`default_nettype none

package video_pkg;

    localparam int CNT_W     = 11;          // raster counter width
    localparam int COPPER_AW = 11;          // copper program address width

    // default raster timing, in pixel clocks and lines
    localparam int H_VISIBLE_DEF = 640;
    localparam int H_FRONT_DEF   = 16;
    localparam int H_SYNC_DEF    = 96;
    localparam int H_BACK_DEF    = 48;
    localparam int V_VISIBLE_DEF = 480;
    localparam int V_FRONT_DEF   = 10;
    localparam int V_SYNC_DEF    = 2;
    localparam int V_BACK_DEF    = 33;
    localparam bit H_POL_DEF     = 1'b0;    // active low hsync
    localparam bit V_POL_DEF     = 1'b0;    // active low vsync
    localparam int VFREQ_DEF     = 'h5994;  // refresh rate as BCD, 59.94 Hz

    // extended register numbers
    typedef enum logic [4:0] {
        XR_VID_CTRL  = 5'h00,
        XR_COPP_CTRL = 5'h01,
        XR_SCANLINE  = 5'h08,
        XR_VID_HSIZE = 5'h0C,
        XR_VID_VSIZE = 5'h0D,
        XR_VID_VFREQ = 5'h0E
    } xr_num_e;

    // sync state order, each state advances to the next one up
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } sync_state_e;

    typedef struct packed {
        logic [7:0]             border;     // border colour index
        logic [3:0]             rsvd;
        logic [3:0]             intr;       // interrupt pulse request bits
    } vid_ctrl_t;

    typedef struct packed {
        logic                   enable;     // copper run enable
        logic [3:0]             rsvd;
        logic [COPPER_AW-1:0]   addr;       // copper start address
    } copp_ctrl_t;

    // one register word, decoded by register number
    typedef union packed {
        vid_ctrl_t              vid_ctrl;
        copp_ctrl_t             copp_ctrl;
    } xr_word_u;

endpackage

`default_nettype wire

// File: hw/video_regs.sv
// video control registers; writes act on a one-cycle strobe, reads return one cycle after reg_num_i
`default_nettype none
`timescale 1ns/100ps

module video_regs import video_pkg::*; #(
    parameter int H_VISIBLE = H_VISIBLE_DEF,
    parameter int V_VISIBLE = V_VISIBLE_DEF,
    parameter int VFREQ     = VFREQ_DEF
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    raster_if.sink              rif,
    input  wire logic           reg_wr_i,       // register write strobe
    input  wire xr_num_e        reg_num_i,      // register number, write and read
    input  wire xr_word_u       reg_data_i,     // write data
    output logic [15:0]         reg_data_o,     // read data, registered
    input  wire logic [3:0]     intr_status_i,  // pending interrupt bits
    output logic [3:0]          intr_o,         // interrupt pulses
    output logic                copp_wr_o,      // copper control write pulse
    output xr_word_u            copp_data_o,    // copper control, held
    output logic [7:0]          color_index_o   // border colour during display
);

    logic [7:0]     border;

    // register writes and one-cycle pulses
    always_ff @(posedge clk) begin
        if (reset_i) begin
            border      <= 8'h08;           // dark grey so a live raster shows
            intr_o      <= 4'b0000;
            copp_wr_o   <= 1'b0;
            copp_data_o <= '0;
        end else begin
            intr_o      <= 4'b0000;
            copp_wr_o   <= 1'b0;

            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        border <= reg_data_i.vid_ctrl.border;
                        intr_o <= reg_data_i.vid_ctrl.intr;
                    end
                    XR_COPP_CTRL: begin
                        copp_wr_o                    <= 1'b1;
                        copp_data_o.copp_ctrl.enable <= reg_data_i.copp_ctrl.enable;
                        copp_data_o.copp_ctrl.addr   <= reg_data_i.copp_ctrl.addr;
                    end
                    default: begin
                    end
                endcase
            end

            // vsync interrupt, shows up on first line of vertical blank
            if (rif.last_visible_pixel) begin
                intr_o[3] <= 1'b1;
            end
        end
    end

    // colour output follows de_o of the timing block
    always_ff @(posedge clk) begin
        if (reset_i) begin
            color_index_o <= 8'h00;
        end else begin
            color_index_o <= rif.de_next ? border : 8'h00;
        end
    end

    // register reads
    always_ff @(posedge clk) begin
        case (reg_num_i)
            XR_VID_CTRL:  reg_data_o <= {border, 4'b0000, intr_status_i};
            XR_COPP_CTRL: reg_data_o <= copp_data_o;    // reserved bits stay zero
            XR_SCANLINE:  reg_data_o <= {rif.v_blank, rif.h_blank, 3'b000, rif.v_count};
            XR_VID_HSIZE: reg_data_o <= 16'(H_VISIBLE);
            XR_VID_VSIZE: reg_data_o <= 16'(V_VISIBLE);
            XR_VID_VFREQ: reg_data_o <= 16'(VFREQ);
            default:      reg_data_o <= 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verif
hw/video_pkg.sv
hw/raster_if.sv
hw/raster_timing.sv
hw/video_regs.sv
hw/video_gen.sv
verif/video_gen_tb.sv

// File: verif/video_gen_checks.svh
// compare tasks and error counters; included inside the testbench module after the video_pkg import
`ifndef VIDEO_GEN_CHECKS_SVH
`define VIDEO_GEN_CHECKS_SVH

int word_errs  = 0;     // 16-bit words, intr and colour
int copp_errs  = 0;
int bit_errs   = 0;
int count_errs = 0;

task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        word_errs++;
        $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_copp(input string what, input xr_word_u got, input xr_word_u exp);
    if (got !== exp) begin
        copp_errs++;
        $display("Mismatch at %0t: %s enable %b addr %h, expected enable %b addr %h",
                 $time, what, got.copp_ctrl.enable, got.copp_ctrl.addr,
                 exp.copp_ctrl.enable, exp.copp_ctrl.addr);
    end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        bit_errs++;
        $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_count(input string what, input logic [CNT_W-1:0] got,
                           input logic [CNT_W-1:0] exp);
    if (got !== exp) begin
        count_errs++;
        $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

`endif

// File: verif/video_gen_tb.sv
// testbench for video_gen on a 14x8 raster; inputs driven and outputs checked on the falling edge
`default_nettype none
`timescale 1ns/100ps

module video_gen_tb import video_pkg::*; ();

    localparam int H_VISIBLE  = 8;
    localparam int H_FRONT    = 2;
    localparam int H_SYNC     = 2;
    localparam int H_BACK     = 2;
    localparam int V_VISIBLE  = 4;
    localparam int V_FRONT    = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 1;
    localparam bit H_POL      = 1'b0;
    localparam bit V_POL      = 1'b1;
    localparam int VFREQ      = 'h7500;         // 75.00 Hz as BCD
    localparam int H_TOTAL    = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL    = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_START    = H_FRONT + H_SYNC + H_BACK;  // first visible pixel
    localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 16;
    localparam int TIMEOUT_NS = (NUM_ROWS + 3) * FRAME_CYC * CLK_PERIOD + 100 * CLK_PERIOD;

    typedef struct {
        xr_num_e        num;
        bit             wr;
        bit             fixed;                  // rd_exp holds the read value
        logic [15:0]    rd_exp;
    } row_t;

    logic               clk = 1'b0;
    logic               reset_i;
    logic               reg_wr_i;
    xr_num_e            reg_num_i;
    xr_word_u           reg_data_i;
    logic [15:0]        reg_data_o;
    logic [3:0]         intr_status_i;
    logic [3:0]         intr_o;
    logic               copp_wr_o;
    xr_word_u           copp_data_o;
    logic [CNT_W-1:0]   h_count_o;
    logic [CNT_W-1:0]   v_count_o;
    logic [7:0]         color_index_o;
    logic               hsync_o;
    logic               vsync_o;
    logic               de_o;

    row_t               tbl [NUM_ROWS];
    int                 m_h;                    // model raster position
    int                 m_v;
    logic [7:0]         m_border;
    xr_word_u           m_copp;
    logic [3:0]         e_intr;                 // expected values for this cycle
    logic               e_cwr;
    logic [7:0]         e_color;
    logic [15:0]        e_rd;

    `include "video_gen_checks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_POL(H_POL), .V_POL(V_POL), .VFREQ(VFREQ)
    ) uut (
        .clk(clk), .reset_i(reset_i),
        .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i), .reg_data_i(reg_data_i),
        .reg_data_o(reg_data_o), .intr_status_i(intr_status_i), .intr_o(intr_o),
        .copp_wr_o(copp_wr_o), .copp_data_o(copp_data_o),
        .h_count_o(h_count_o), .v_count_o(v_count_o), .color_index_o(color_index_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o)
    );

    task automatic load_table();
        tbl[0]  = '{XR_VID_HSIZE, 1'b0, 1'b1, 16'(H_VISIBLE)};
        tbl[1]  = '{XR_VID_VSIZE, 1'b0, 1'b1, 16'(V_VISIBLE)};
        tbl[2]  = '{XR_VID_VFREQ, 1'b0, 1'b1, 16'(VFREQ)};
        tbl[3]  = '{XR_VID_CTRL,  1'b0, 1'b0, 16'h0000};   // border still at reset value
        tbl[4]  = '{XR_SCANLINE,  1'b0, 1'b0, 16'h0000};
        tbl[5]  = '{xr_num_e'(5'h03), 1'b0, 1'b1, 16'h0000};
        tbl[6]  = '{XR_VID_CTRL,  1'b1, 1'b0, 16'h0000};
        tbl[7]  = '{XR_VID_CTRL,  1'b0, 1'b0, 16'h0000};
        tbl[8]  = '{XR_COPP_CTRL, 1'b1, 1'b0, 16'h0000};
        tbl[9]  = '{XR_COPP_CTRL, 1'b0, 1'b0, 16'h0000};
        tbl[10] = '{XR_SCANLINE,  1'b0, 1'b0, 16'h0000};
        tbl[11] = '{XR_VID_CTRL,  1'b1, 1'b0, 16'h0000};
        tbl[12] = '{XR_COPP_CTRL, 1'b1, 1'b0, 16'h0000};
        tbl[13] = '{XR_COPP_CTRL, 1'b0, 1'b0, 16'h0000};
        tbl[14] = '{XR_VID_CTRL,  1'b0, 1'b0, 16'h0000};
        tbl[15] = '{xr_num_e'(5'h1F), 1'b0, 1'b1, 16'h0000};
    endtask

    function automatic logic de_at(input int h, input int v);
        return (h >= H_START) && (v < V_VISIBLE);
    endfunction

    // read value for the register number taken at the coming edge
    function automatic logic [15:0] expected_read(input xr_num_e num);
        logic [15:0] val;
        case (num)
            XR_VID_CTRL:  val = {m_border, 4'b0000, intr_status_i};
            XR_COPP_CTRL: val = m_copp;
            XR_SCANLINE:  val = {m_v >= V_VISIBLE, m_h < H_START, 3'b000, CNT_W'(m_v)};
            XR_VID_HSIZE: val = 16'(H_VISIBLE);
            XR_VID_VSIZE: val = 16'(V_VISIBLE);
            XR_VID_VFREQ: val = 16'(VFREQ);
            default:      val = 16'h0000;
        endcase
        return val;
    endfunction

    task automatic check_outputs(input bit chk_rd);
        check_count("h_count_o", h_count_o, CNT_W'(m_h));
        check_count("v_count_o", v_count_o, CNT_W'(m_v));
        check_bit("hsync_o", hsync_o,
                  (m_h >= H_FRONT && m_h < H_FRONT + H_SYNC) ? H_POL : !H_POL);
        check_bit("vsync_o", vsync_o, (m_v >= V_VISIBLE + V_FRONT &&
                  m_v < V_VISIBLE + V_FRONT + V_SYNC) ? V_POL : !V_POL);
        check_bit("de_o", de_o, de_at(m_h, m_v));
        check_word("intr_o", {12'h000, intr_o}, {12'h000, e_intr});
        check_word("color_index_o", {8'h00, color_index_o}, {8'h00, e_color});
        check_bit("copp_wr_o", copp_wr_o, e_cwr);
        check_copp("copp_data_o", copp_data_o, m_copp);
        if (chk_rd) begin
            check_word("reg_data_o", reg_data_o, e_rd);
        end
    endtask

    // advance the model over one rising edge, then check the DUT at the falling edge
    task automatic step(input bit chk_rd, input bit fixed, input logic [15:0] fixed_val);
        logic vid_wr;
        logic copp_wr;
        vid_wr  = reg_wr_i && (reg_num_i == XR_VID_CTRL);
        copp_wr = reg_wr_i && (reg_num_i == XR_COPP_CTRL);
        e_rd    = fixed ? fixed_val : expected_read(reg_num_i);
        if (m_h == H_TOTAL - 1) begin
            m_h = 0;
            m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
        end else begin
            m_h = m_h + 1;
        end
        e_color = de_at(m_h, m_v) ? m_border : 8'h00;   // new border one cycle later
        e_intr  = vid_wr ? reg_data_i.vid_ctrl.intr : 4'b0000;
        if (m_h == 0 && m_v == V_VISIBLE) begin
            e_intr[3] = 1'b1;                           // vsync event
        end
        e_cwr = copp_wr;
        if (vid_wr) begin
            m_border = reg_data_i.vid_ctrl.border;
        end
        if (copp_wr) begin
            m_copp = '0;
            m_copp.copp_ctrl.enable = reg_data_i.copp_ctrl.enable;
            m_copp.copp_ctrl.addr   = reg_data_i.copp_ctrl.addr;
        end
        @(negedge clk);
        check_outputs(chk_rd);
    endtask

    initial begin
        int idle;
        reset_i       = 1'b1;
        reg_wr_i      = 1'b0;
        reg_num_i     = XR_VID_CTRL;
        reg_data_i    = '0;
        intr_status_i = 4'h0;
        void'($urandom(32'h3f6b_2549));
        load_table();
        m_h      = 0;
        m_v      = 0;
        m_border = 8'h08;
        m_copp   = '0;
        e_intr   = 4'b0000;
        e_cwr    = 1'b0;
        e_color  = 8'h00;
        e_rd     = 16'h0000;
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
        check_outputs(1'b0);                            // state left by reset
        repeat (3 * FRAME_CYC) step(1'b0, 1'b0, 16'h0000);
        for (int r = 0; r < NUM_ROWS; r++) begin
            reg_num_i     = tbl[r].num;
            reg_wr_i      = tbl[r].wr;
            reg_data_i    = 16'($urandom);
            intr_status_i = 4'($urandom);
            step(!tbl[r].wr, tbl[r].fixed, tbl[r].rd_exp);
            reg_wr_i = 1'b0;
            idle = 90 + int'($urandom % 20);            // moves the next row along the raster
            repeat (idle) step(1'b0, 1'b0, 16'h0000);
        end
        $display("Error counts: word %0d, copper %0d, bit %0d, count %0d",
                 word_errs, copp_errs, bit_errs, count_errs);
        if (word_errs + copp_errs + bit_errs + count_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not complete in %0d ns", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
